/* Bender.yml */
package:
  name: bnn_neuron

sources:
  - include_dirs:
      - source
    files:
      - source/bnn_pkg.sv
      - source/neuron_param_store.sv
      - source/xnor_popcount_tree.sv
      - source/threshold_accumulator.sv
      - source/bnn_neuron_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/bnn_neuron_asserts.sv
      - verification/bnn_neuron_tb.sv

/* filelist.f */
+incdir+source
source/bnn_pkg.sv
source/neuron_param_store.sv
source/xnor_popcount_tree.sv
source/threshold_accumulator.sv
source/bnn_neuron_top.sv
verification/bnn_neuron_asserts.sv
verification/bnn_neuron_tb.sv

/* source/bnn_cfg.svh */
`ifndef BNN_CFG_SVH
`define BNN_CFG_SVH

// Bits per activation and weight vector, a power of two
`define BNN_VEC_WIDTH 128

// Entries held in each bank of the parameter store
`define BNN_ENTRIES 8

// Pre-activation sum and threshold width
`define BNN_ACC_WIDTH 16

`endif

/* source/bnn_neuron_top.sv */
`include "bnn_cfg.svh"

`default_nettype none

module bnn_neuron_top (
	input  wire                      clk,
	input  wire                      rstn,

	// Parameter writes
	input  wire                      wr_en,
	input  bnn_pkg::store_sel_t      wr_sel,
	input  bnn_pkg::entry_addr_t     wr_addr,
	input  bnn_pkg::vec_t            wr_data,

	// Sample request
	input  wire                      sample,
	input  bnn_pkg::entry_addr_t     addr,

	input  wire                      acc_clear,

	output bnn_pkg::acc_t            pre_activation,
	output logic                     fire
);

	bnn_pkg::vec_t  act_q;
	bnn_pkg::vec_t  wgt_q;
	bnn_pkg::acc_t  thr_q;
	logic           fetch_valid;
	bnn_pkg::count_t count_q;
	logic           count_valid;

	// Operand fetch, edge k
	neuron_param_store i_param_store (
		.clk         (clk),
		.rstn        (rstn),
		.wr_en       (wr_en),
		.wr_sel      (wr_sel),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.sample      (sample),
		.addr        (addr),
		.act_q       (act_q),
		.wgt_q       (wgt_q),
		.thr_q       (thr_q),
		.fetch_valid (fetch_valid)
	);

	// Match count, edge k+1
	xnor_popcount_tree #(
		.N (`BNN_VEC_WIDTH)
	) i_popcount_tree (
		.clk         (clk),
		.rstn        (rstn),
		.act         (act_q),
		.wgt         (wgt_q),
		.in_valid    (fetch_valid),
		.count_q     (count_q),
		.count_valid (count_valid)
	);

	// Accumulate and compare, edge k+2
	threshold_accumulator i_accumulator (
		.clk            (clk),
		.rstn           (rstn),
		.count          (count_q),
		.count_valid    (count_valid),
		.thr            (thr_q),
		.acc_clear      (acc_clear),
		.pre_activation (pre_activation),
		.fire           (fire)
	);

endmodule

`default_nettype wire

/* source/bnn_pkg.sv */
`include "bnn_cfg.svh"

`default_nettype none

package bnn_pkg;

	localparam int WORD_WIDTH = 32;
	localparam int VEC_WORDS = `BNN_VEC_WIDTH / WORD_WIDTH;
	localparam int COUNT_WIDTH = $clog2(`BNN_VEC_WIDTH) + 1;
	localparam int ADDR_WIDTH = $clog2(`BNN_ENTRIES);

	// Vector seen as 32-bit words, word 0 in the low bits
	typedef logic [VEC_WORDS-1:0][WORD_WIDTH-1:0] vec_t;

	// Match count, 0 up to the full vector width
	typedef logic [COUNT_WIDTH-1:0] count_t;

	typedef logic [`BNN_ACC_WIDTH-1:0] acc_t;

	typedef logic [ADDR_WIDTH-1:0] entry_addr_t;

	// Bank targeted by a write
	typedef enum logic [1:0] {
		SEL_ACT = 2'd0,
		SEL_WGT = 2'd1,
		SEL_THR = 2'd2
	} store_sel_t;

endpackage

`default_nettype wire

/* source/neuron_param_store.sv */
`include "bnn_cfg.svh"

`default_nettype none

module neuron_param_store (
	input  wire                      clk,
	input  wire                      rstn,

	// Write port, one bank per write
	input  wire                      wr_en,
	input  bnn_pkg::store_sel_t      wr_sel,
	input  bnn_pkg::entry_addr_t     wr_addr,
	input  bnn_pkg::vec_t            wr_data,

	// Sample port
	input  wire                      sample,
	input  bnn_pkg::entry_addr_t     addr,

	output bnn_pkg::vec_t            act_q,
	output bnn_pkg::vec_t            wgt_q,
	output bnn_pkg::acc_t            thr_q,
	output logic                     fetch_valid
);

	bnn_pkg::vec_t act_mem [`BNN_ENTRIES];
	bnn_pkg::vec_t wgt_mem [`BNN_ENTRIES];
	bnn_pkg::acc_t thr_mem [`BNN_ENTRIES];

	// Threshold lives in the low bits of word 0
	bnn_pkg::acc_t wr_thr;

	assign wr_thr = wr_data[0][`BNN_ACC_WIDTH-1:0];

	// Bank writes, no reset on the storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wr_sel)
				bnn_pkg::SEL_ACT: begin
					act_mem[wr_addr] <= wr_data;
				end
				bnn_pkg::SEL_WGT: begin
					wgt_mem[wr_addr] <= wr_data;
				end
				bnn_pkg::SEL_THR: begin
					thr_mem[wr_addr] <= wr_thr;
				end
				default: begin
				end
			endcase
		end
	end

	// Registered read of all three banks
	// a write at the same edge is not yet visible here
	always_ff @(posedge clk) begin
		if (rstn) begin
			act_q <= '0;
			wgt_q <= '0;
			thr_q <= '0;
		end else if (sample) begin
			act_q <= act_mem[addr];
			wgt_q <= wgt_mem[addr];
			thr_q <= thr_mem[addr];
		end
	end

	// One-cycle strobe per sample
	always_ff @(posedge clk) begin
		if (rstn) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= sample;
		end
	end

endmodule

`default_nettype wire

/* source/threshold_accumulator.sv */
`default_nettype none

module threshold_accumulator (
	input  wire                      clk,
	input  wire                      rstn,

	input  bnn_pkg::count_t          count,
	input  wire                      count_valid,
	input  bnn_pkg::acc_t            thr,
	input  wire                      acc_clear,

	output bnn_pkg::acc_t            pre_activation,
	output logic                     fire
);

	// Threshold one stage late, in step with the count
	bnn_pkg::acc_t thr_d;
	// Threshold of the last accumulated entry
	bnn_pkg::acc_t thr_cap;
	bnn_pkg::acc_t acc_next;

	// Wraps modulo the accumulator width
	assign acc_next = pre_activation + bnn_pkg::acc_t'(count);

	always_ff @(posedge clk) begin
		if (rstn) begin
			thr_d <= '0;
		end else begin
			thr_d <= thr;
		end
	end

	// Clear wins over an arriving count
	always_ff @(posedge clk) begin
		if (rstn) begin
			pre_activation <= '0;
			thr_cap <= '0;
		end else if (acc_clear) begin
			pre_activation <= '0;
			thr_cap <= '0;
		end else if (count_valid) begin
			pre_activation <= acc_next;
			thr_cap <= thr_d;
		end
	end

	// Sum and threshold both come from registers, so fire changes only with them
	assign fire = pre_activation > thr_cap;

endmodule

`default_nettype wire

/* source/xnor_popcount_tree.sv */
`default_nettype none

module xnor_popcount_tree #(
	parameter int N = 128
) (
	input  wire                      clk,
	input  wire                      rstn,

	// Operand vectors, both N bits wide
	input  wire [N-1:0]              act,
	input  wire [N-1:0]              wgt,
	input  wire                      in_valid,

	// Number of matching bit positions, 0 to N
	output logic [$clog2(N):0]       count_q,
	output logic                     count_valid
);

	localparam int LEVELS = $clog2(N);

	if ((1 << LEVELS) != N) begin : g_width_check
		$error("xnor_popcount_tree needs N to be a power of two");
	end

	// One bit per position where activation and weight agree
	logic [N-1:0] match;

	assign match = act ~^ wgt;

	// Level lv holds N >> lv partial sums of lv + 1 bits each
	// level 0 is the match vector itself
	for (genvar lv = 0; lv <= LEVELS; lv++) begin : g_level
		logic [(N >> lv)-1:0][lv:0] part;

		if (lv == 0) begin : g_leaf
			assign part = match;
		end else begin : g_add
			for (genvar i = 0; i < (N >> lv); i++) begin : g_node
				// Pair of neighbours from the level above, one bit wider
				assign part[i] = g_level[lv-1].part[2*i] +
					g_level[lv-1].part[2*i+1];
			end
		end
	end

	// Root of the tree, the full match count
	logic [LEVELS:0] count_d;

	assign count_d = g_level[LEVELS].part[0];

	// Count register, loaded only for a valid fetch
	always_ff @(posedge clk) begin
		if (rstn) begin
			count_q <= '0;
		end else if (in_valid) begin
			count_q <= count_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			count_valid <= 1'b0;
		end else begin
			count_valid <= in_valid;
		end
	end

endmodule

`default_nettype wire

/* verification/bnn_neuron_asserts.sv */
`include "bnn_cfg.svh"

`default_nettype none

module bnn_neuron_asserts (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire                      wr_en,
	input  bnn_pkg::store_sel_t      wr_sel,
	input  bnn_pkg::entry_addr_t     wr_addr,
	input  bnn_pkg::vec_t            wr_data,
	input  wire                      sample,
	input  bnn_pkg::entry_addr_t     addr,
	input  wire                      acc_clear,
	input  bnn_pkg::acc_t            pre_activation,
	input  wire                      fire
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Shadow copy of the three banks
	bnn_pkg::vec_t shadow_act [`BNN_ENTRIES];
	bnn_pkg::vec_t shadow_wgt [`BNN_ENTRIES];
	bnn_pkg::acc_t shadow_thr [`BNN_ENTRIES];
	logic [`BNN_VEC_WIDTH-1:0] wr_flat;

	// Sample pipeline of the model
	logic s1_valid;
	logic s2_valid;
	bnn_pkg::vec_t s1_act;
	bnn_pkg::vec_t s1_wgt;
	bnn_pkg::acc_t s1_thr;
	bnn_pkg::acc_t s2_thr;
	bnn_pkg::count_t s2_count;
	bnn_pkg::acc_t model_sum;
	bnn_pkg::acc_t model_thr;

	function automatic bnn_pkg::count_t equal_bits(input logic [`BNN_VEC_WIDTH-1:0] a,
			input logic [`BNN_VEC_WIDTH-1:0] b);
		bnn_pkg::count_t n;
		n = '0;
		for (int i = 0; i < `BNN_VEC_WIDTH; i++) begin
			if (a[i] == b[i]) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	assign wr_flat = wr_data;

	// Nonblocking update, so a read at the write edge sees old data
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wr_sel)
				bnn_pkg::SEL_ACT: shadow_act[wr_addr] <= wr_data;
				bnn_pkg::SEL_WGT: shadow_wgt[wr_addr] <= wr_data;
				bnn_pkg::SEL_THR: shadow_thr[wr_addr] <= wr_flat[`BNN_ACC_WIDTH-1:0];
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s1_act <= '0;
			s1_wgt <= '0;
			s1_thr <= '0;
			s2_thr <= '0;
			s2_count <= '0;
			model_sum <= '0;
			model_thr <= '0;
		end else begin
			s1_valid <= sample;
			if (sample) begin
				s1_act <= shadow_act[addr];
				s1_wgt <= shadow_wgt[addr];
				s1_thr <= shadow_thr[addr];
			end
			s2_valid <= s1_valid;
			s2_count <= equal_bits(s1_act, s1_wgt);
			s2_thr <= s1_thr;
			if (acc_clear) begin
				model_sum <= '0;
				model_thr <= '0;
			end else if (s2_valid) begin
				model_sum <= model_sum + s2_count;
				model_thr <= s2_thr;
			end
		end
	end

	a_sum: assert property (@(posedge clk) disable iff (rstn) pre_activation == model_sum)
		else begin
			fail_count++;
			$error("[FAIL] %0t pre_activation is %0d, expected %0d", $time,
				$sampled(pre_activation), $sampled(model_sum));
		end

	a_fire: assert property (@(posedge clk) disable iff (rstn)
			fire == (model_sum > model_thr))
		else begin
			fail_count++;
			$error("[FAIL] %0t fire is %0b, expected %0b with sum %0d and threshold %0d",
				$time, $sampled(fire), $sampled(model_sum > model_thr),
				$sampled(model_sum), $sampled(model_thr));
		end

	a_clear: assert property (@(posedge clk) disable iff (rstn)
			acc_clear |=> (pre_activation == '0 && !fire))
		else begin
			fail_count++;
			$error("Sum or fire was not cleared on the cycle after acc_clear");
		end

	// No count reaching the accumulator means nothing moves
	a_hold: assert property (@(posedge clk) disable iff (rstn)
			(!s2_valid && !acc_clear) |=> ($stable(pre_activation) && $stable(fire)))
		else begin
			fail_count++;
			$error("pre_activation or fire changed in a cycle without a valid count");
		end

	a_reset: assert property (@(posedge clk) $fell(rstn) |-> (pre_activation == '0 && !fire))
		else begin
			fail_count++;
			$error("pre_activation or fire was not zero when reset was released");
		end

endmodule

`default_nettype wire

/* verification/bnn_neuron_tb.sv */
`include "bnn_cfg.svh"

`default_nettype none

module bnn_neuron_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 4;
	localparam int WRAP_SAMPLES = 520;

	// Cycle budget of each test, for the watchdog
	localparam int T1_CYCLES = 4;
	localparam int T2_CYCLES = 4 * `BNN_ENTRIES + 1 + DRAIN_CYCLES;
	localparam int T3_CYCLES = 2 * `BNN_ENTRIES + 1 + DRAIN_CYCLES;
	localparam int T4_CYCLES = 14;
	localparam int T5_CYCLES = 14;
	localparam int T6_CYCLES = 4 + WRAP_SAMPLES + DRAIN_CYCLES;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
		T4_CYCLES + T5_CYCLES + T6_CYCLES + MARGIN_CYCLES;

	logic                 clk;
	logic                 rstn;
	logic                 wr_en;
	bnn_pkg::store_sel_t  wr_sel;
	bnn_pkg::entry_addr_t wr_addr;
	bnn_pkg::vec_t        wr_data;
	logic                 sample;
	bnn_pkg::entry_addr_t addr;
	logic                 acc_clear;
	bnn_pkg::acc_t        pre_activation;
	logic                 fire;

	integer seed;
	int fails_at_start;
	int tests_run;
	int tests_failed;

	bind bnn_neuron_top bnn_neuron_asserts i_asserts (.*);

	bnn_neuron_top i_bnn_neuron_top (
		.clk            (clk),
		.rstn           (rstn),
		.wr_en          (wr_en),
		.wr_sel         (wr_sel),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.sample         (sample),
		.addr           (addr),
		.acc_clear      (acc_clear),
		.pre_activation (pre_activation),
		.fire           (fire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// One cycle of stimulus, seen by the DUT at the next edge
	task automatic drive_cycle(input logic w_en, input bnn_pkg::store_sel_t sel,
			input bnn_pkg::entry_addr_t w_addr, input bnn_pkg::vec_t w_data,
			input logic smp, input bnn_pkg::entry_addr_t s_addr, input logic clr);
		@(posedge clk);
		wr_en <= w_en;
		wr_sel <= sel;
		wr_addr <= w_addr;
		wr_data <= w_data;
		sample <= smp;
		addr <= s_addr;
		acc_clear <= clr;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, bnn_pkg::SEL_ACT, '0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic write_entry(input bnn_pkg::store_sel_t sel, input int a,
			input bnn_pkg::vec_t d);
		drive_cycle(1'b1, sel, bnn_pkg::entry_addr_t'(a), d, 1'b0, '0, 1'b0);
	endtask

	task automatic sample_entry(input int a, input logic clr);
		drive_cycle(1'b0, bnn_pkg::SEL_ACT, '0, '0, 1'b1, bnn_pkg::entry_addr_t'(a), clr);
	endtask

	task automatic clear_sum();
		drive_cycle(1'b0, bnn_pkg::SEL_ACT, '0, '0, 1'b0, '0, 1'b1);
	endtask

	function automatic bnn_pkg::vec_t random_vec();
		bnn_pkg::vec_t v;
		for (int w = 0; w < bnn_pkg::VEC_WORDS; w++) begin
			v[w] = $random(seed);
		end
		return v;
	endfunction

	// Threshold sits in the low bits of the write word
	function automatic bnn_pkg::vec_t thr_word(input int t);
		bnn_pkg::vec_t v;
		v = '0;
		v[0][`BNN_ACC_WIDTH-1:0] = t[`BNN_ACC_WIDTH-1:0];
		return v;
	endfunction

	task automatic begin_test();
		fails_at_start = i_bnn_neuron_top.i_asserts.fail_count;
	endtask

	task automatic end_test(input string name);
		int fired;
		// Assertions of the last edge report later in that time step
		@(negedge clk);
		fired = i_bnn_neuron_top.i_asserts.fail_count - fails_at_start;
		tests_run++;
		if (fired == 0) begin
			$display("%s: finished, no assertion fired", name);
		end else begin
			tests_failed++;
			$display("%s: finished, %0d assertion failures", name, fired);
		end
	endtask

	initial begin
		int offset;
		seed = 59;
		rstn = 1'b1;
		wr_en = 1'b0;
		wr_sel = bnn_pkg::SEL_ACT;
		wr_addr = '0;
		wr_data = '0;
		sample = 1'b0;
		addr = '0;
		acc_clear = 1'b0;
		tests_run = 0;
		tests_failed = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b0;

		begin_test();
		idle(T1_CYCLES);
		end_test("reset_values");

		// Random entries, then back to back samples
		begin_test();
		for (int e = 0; e < `BNN_ENTRIES; e++) begin
			write_entry(bnn_pkg::SEL_ACT, e, random_vec());
			write_entry(bnn_pkg::SEL_WGT, e, random_vec());
			write_entry(bnn_pkg::SEL_THR, e, random_vec());
		end
		clear_sum();
		for (int e = 0; e < `BNN_ENTRIES; e++) begin
			sample_entry(e, 1'b0);
		end
		idle(DRAIN_CYCLES);
		end_test("accumulate_back_to_back");

		// Sum grows by about 64 per entry, thresholds alternate around it
		begin_test();
		for (int e = 0; e < `BNN_ENTRIES; e++) begin
			offset = (e % 2 == 1) ? 30 : -30;
			write_entry(bnn_pkg::SEL_THR, e, thr_word(64 * (e + 1) + offset));
		end
		clear_sum();
		for (int e = 0; e < `BNN_ENTRIES; e++) begin
			sample_entry(e, 1'b0);
		end
		idle(DRAIN_CYCLES);
		end_test("fire_threshold");

		// Clear lands on the edge where the count of sample 1 arrives
		begin_test();
		clear_sum();
		for (int e = 0; e < 6; e++) begin
			sample_entry(e, e == 3);
		end
		idle(DRAIN_CYCLES);
		clear_sum();
		idle(2);
		end_test("clear_in_flight");

		begin_test();
		idle(3);
		drive_cycle(1'b1, bnn_pkg::SEL_ACT, 3'd2, random_vec(), 1'b1, 3'd2, 1'b0);
		drive_cycle(1'b1, bnn_pkg::SEL_WGT, 3'd5, random_vec(), 1'b1, 3'd5, 1'b0);
		drive_cycle(1'b1, bnn_pkg::SEL_THR, 3'd2, thr_word(0), 1'b1, 3'd2, 1'b0);
		idle(2);
		sample_entry(2, 1'b0);
		sample_entry(5, 1'b0);
		idle(DRAIN_CYCLES);
		end_test("hold_and_write_collision");

		// Every bit matches, so each sample adds the full width
		begin_test();
		clear_sum();
		write_entry(bnn_pkg::SEL_ACT, 0, '1);
		write_entry(bnn_pkg::SEL_WGT, 0, '1);
		write_entry(bnn_pkg::SEL_THR, 0, thr_word(1000));
		repeat (WRAP_SAMPLES) sample_entry(0, 1'b0);
		idle(DRAIN_CYCLES);
		end_test("sum_wrap");

		$display("tests run %0d, failed %0d, assertion failures %0d", tests_run,
			tests_failed, i_bnn_neuron_top.i_asserts.fail_count);
		if (tests_failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
